/* Makefile */
SIM = obj_dir/ctn_ram_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
	  --top-module ctn_ram_tb -Mdir obj_dir -o ctn_ram_sim
	@./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then \
	  echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* hw/ctn_pkg.sv */
/*
 * Shared definitions for the CTN memory path: address map, RAM sizes,
 * power-on constants, the address union and the request/response structs
 */
`default_nettype none

package ctn_pkg;

  //////////////////////////////////////////////////////////////////////
  // Address map and sizes
  //////////////////////////////////////////////////////////////////////

  localparam logic [31:0] CtnBaseAddr  = 32'h4000_0000;
  localparam logic [31:0] RamOffset    = 32'h0010_0000;  // RAM window inside CTN space
  localparam int          RamSizeBytes = 1024;
  localparam int          RamDepth     = 256;            // Words
  localparam int          DataWidth    = 32;
  localparam int          MaskWidth    = 4;
  localparam int          ByteWidth    = DataWidth / MaskWidth;
  localparam int          AddrWidth    = 32;

  // Address split derived from the window size
  localparam int RamAddrBits = $clog2(RamSizeBytes);
  localparam int OffWidth    = $clog2(MaskWidth);
  localparam int IdxWidth    = $clog2(RamDepth);
  localparam int TagWidth    = AddrWidth - RamAddrBits;

  // Upper address bits every RAM access must carry
  localparam logic [TagWidth-1:0] RamTag =
      TagWidth'((CtnBaseAddr + RamOffset) >> RamAddrBits);

  // Power-on sequencer
  localparam int PorSatCount = 15;
  localparam int PorCntWidth = $clog2(PorSatCount + 1);

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [TagWidth-1:0] tag;  // Window tag
    logic [IdxWidth-1:0] idx;  // Word index
    logic [OffWidth-1:0] off;  // Byte inside the word
  } ctn_addr_fields_t;

  // Same address word, seen whole or split
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    ctn_addr_fields_t     fields;
  } ctn_addr_u;

  // Request from the CTN port
  typedef struct packed {
    logic                 valid;
    logic                 write;
    ctn_addr_u            addr;
    logic [MaskWidth-1:0] mask;
    logic [DataWidth-1:0] wdata;
  } ctn_req_t;

  // Decoded operation towards the RAM
  typedef struct packed {
    logic                 valid;
    logic                 hit;    // Address inside the RAM window
    logic                 write;
    logic [IdxWidth-1:0]  idx;
    logic [MaskWidth-1:0] mask;
    logic [DataWidth-1:0] wdata;
  } ctn_ram_op_t;

  // Response back to the CTN port
  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic                 error;
    logic [DataWidth-1:0] rdata;
  } ctn_rsp_t;

endpackage

`default_nettype wire

/* hw/ctn_por_seq.sv */
/*
 * Fake power-on sequencer: saturating counter, supply-good pattern
 * and the ready level that releases the memory path
 */
`timescale 1ns/1ps
`default_nettype none

module ctn_por_seq (
  input  wire  clk_aon,
  input  wire  rst_n_i,
  output logic supply_ok_o,
  output logic ready_o
);

  localparam logic [ctn_pkg::PorCntWidth-1:0] SatVal =
      ctn_pkg::PorCntWidth'(ctn_pkg::PorSatCount);

  logic [ctn_pkg::PorCntWidth-1:0] cnt_q;

  // Count up once per edge, then hold
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q != SatVal) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Supply dips once before it settles
  always_comb begin
    if (cnt_q < 4'd4) begin
      supply_ok_o = 1'b0;
    end else if (cnt_q < 4'd8) begin
      supply_ok_o = 1'b1;      // First, short good phase
    end else if (cnt_q < 4'd12) begin
      supply_ok_o = 1'b0;
    end else begin
      supply_ok_o = 1'b1;
    end
  end

  assign ready_o = (cnt_q == SatVal);  // Sticky, counter never leaves saturation

endmodule

`default_nettype wire

/* hw/ctn_ram_stage.sv */
/*
 * Second pipeline stage: single-port RAM with byte-masked writes,
 * registered read data and the operation carried along
 */
`timescale 1ns/1ps
`default_nettype none

module ctn_ram_stage (
  input  wire                                  clk_aon,
  input  wire                                  rst_n_i,
  input  ctn_pkg::ctn_ram_op_t                 op_i,
  output ctn_pkg::ctn_ram_op_t                 op_o,
  output logic [ctn_pkg::DataWidth-1:0]        rdata_o
);

  logic [ctn_pkg::DataWidth-1:0] mem [ctn_pkg::RamDepth];
  logic [ctn_pkg::DataWidth-1:0] rdata_q;
  ctn_pkg::ctn_ram_op_t          op_q;
  logic                          valid_q;
  logic                          wr_en;
  logic                          rd_en;

  // Misses never reach the array
  assign wr_en = op_i.valid & op_i.hit & op_i.write;
  assign rd_en = op_i.valid & op_i.hit & ~op_i.write;

  //////////////////////////////////////////////////////////////////////
  // Array
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    if (wr_en) begin
      for (int b = 0; b < ctn_pkg::MaskWidth; b++) begin
        if (op_i.mask[b]) begin
          mem[op_i.idx][b*ctn_pkg::ByteWidth +: ctn_pkg::ByteWidth] <=
              op_i.wdata[b*ctn_pkg::ByteWidth +: ctn_pkg::ByteWidth];
        end
      end
    end
  end

  // Output pipeline register for read data
  always_ff @(posedge clk_aon) begin
    if (rd_en) begin
      rdata_q <= mem[op_i.idx];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operation carried to the response stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= op_i.valid;
    end
  end

  always_ff @(posedge clk_aon) begin
    if (op_i.valid) begin
      op_q <= op_i;  // Kind and hit flag for the response
    end
  end

  always_comb begin
    op_o       = op_q;
    op_o.valid = valid_q;
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hw/ctn_ram_top.sv */
/*
 * CTN memory path top level: power-on sequencer and the three-stage
 * decode, RAM and response pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module ctn_ram_top (
  input  wire                clk_aon,
  input  wire                rst_n_i,
  input  ctn_pkg::ctn_req_t  req_i,
  output ctn_pkg::ctn_rsp_t  rsp_o,
  output logic               supply_ok_o,
  output logic               ready_o
);

  logic                          ready;
  ctn_pkg::ctn_ram_op_t          dec_op;
  ctn_pkg::ctn_ram_op_t          ram_op;
  logic [ctn_pkg::DataWidth-1:0] ram_rdata;

  //////////////////////////////////////////////////////////////////////
  // Power-on
  //////////////////////////////////////////////////////////////////////

  ctn_por_seq u_por (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n_i),
    .supply_ok_o (supply_ok_o),
    .ready_o     (ready)
  );

  assign ready_o = ready;

  //////////////////////////////////////////////////////////////////////
  // Memory path, request to response in three edges
  //////////////////////////////////////////////////////////////////////

  ctn_req_decode u_decode (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .ready_i (ready),
    .req_i   (req_i),
    .op_o    (dec_op)
  );

  ctn_ram_stage u_ram (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .op_i    (dec_op),
    .op_o    (ram_op),
    .rdata_o (ram_rdata)
  );

  ctn_rsp_stage u_rsp (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .op_i    (ram_op),
    .rdata_i (ram_rdata),
    .rsp_o   (rsp_o)
  );

endmodule

`default_nettype wire

/* hw/ctn_req_decode.sv */
/*
 * First pipeline stage: window check on the incoming request and
 * registered operation towards the RAM
 */
`timescale 1ns/1ps
`default_nettype none

module ctn_req_decode (
  input  wire                  clk_aon,
  input  wire                  rst_n_i,
  input  logic                 ready_i,
  input  ctn_pkg::ctn_req_t    req_i,
  output ctn_pkg::ctn_ram_op_t op_o
);

  ctn_pkg::ctn_ram_op_t op_d;
  ctn_pkg::ctn_ram_op_t op_q;
  logic                 valid_q;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    op_d.valid = req_i.valid & ready_i;  // Nothing enters before power-on is done
    op_d.hit   = (req_i.addr.fields.tag == ctn_pkg::RamTag);
    op_d.write = req_i.write;
    op_d.idx   = req_i.addr.fields.idx;
    op_d.mask  = req_i.mask;
    op_d.wdata = req_i.wdata;
  end

  //////////////////////////////////////////////////////////////////////
  // Input pipeline register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= op_d.valid;
    end
  end

  // Payload only loads with a live request
  always_ff @(posedge clk_aon) begin
    if (op_d.valid) begin
      op_q <= op_d;
    end
  end

  always_comb begin
    op_o       = op_q;
    op_o.valid = valid_q;
  end

endmodule

`default_nettype wire

/* hw/ctn_rsp_stage.sv */
/*
 * Third pipeline stage: registered response word with error flag
 */
`timescale 1ns/1ps
`default_nettype none

module ctn_rsp_stage (
  input  wire                           clk_aon,
  input  wire                           rst_n_i,
  input  ctn_pkg::ctn_ram_op_t          op_i,
  input  logic [ctn_pkg::DataWidth-1:0] rdata_i,
  output ctn_pkg::ctn_rsp_t             rsp_o
);

  ctn_pkg::ctn_rsp_t rsp_d;
  ctn_pkg::ctn_rsp_t rsp_q;
  logic              valid_q;

  always_comb begin
    rsp_d.valid = op_i.valid;
    rsp_d.write = op_i.write;
    rsp_d.error = ~op_i.hit;  // Outside the RAM window
    // Data only for read hits, zero for writes and misses
    rsp_d.rdata = (op_i.hit && !op_i.write) ? rdata_i : '0;
  end

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rsp_d.valid;
    end
  end

  always_ff @(posedge clk_aon) begin
    if (rsp_d.valid) begin
      rsp_q <= rsp_d;
    end
  end

  always_comb begin
    rsp_o       = rsp_q;
    rsp_o.valid = valid_q;
  end

endmodule

`default_nettype wire

/* list.f */
hw/ctn_pkg.sv
hw/ctn_por_seq.sv
hw/ctn_req_decode.sv
hw/ctn_ram_stage.sv
hw/ctn_rsp_stage.sv
hw/ctn_ram_top.sv
sim/ctn_ram_asserts.sv
sim/ctn_ram_tb.sv

/* sim/ctn_patterns.txt */
// Columns, hex: write addr mask wdata exp_error exp_rdata
// One request per line; writes and misses expect read data 0
1 40100000 f 11223344 0 00000000
0 40100000 f 00000000 0 11223344
1 40100004 f a5a5a5a5 0 00000000
0 40100004 f 00000000 0 a5a5a5a5
1 401003fc f cafef00d 0 00000000
0 401003fc f 00000000 0 cafef00d
1 40100004 1 000000ff 0 00000000
0 40100004 f 00000000 0 a5a5a5ff
1 40100004 6 12345600 0 00000000
0 40100004 f 00000000 0 a53456ff
1 40100004 8 77000000 0 00000000
0 40100004 0 00000000 0 773456ff
1 40100008 f 0f0f0f0f 0 00000000
1 40100008 0 ffffffff 0 00000000
0 40100008 f 00000000 0 0f0f0f0f
1 40100400 f deadbeef 1 00000000
0 40100000 f 00000000 0 11223344
0 40100400 f 00000000 1 00000000
1 40000000 f deadbeef 1 00000000
1 3ff00004 f 0badf00d 1 00000000
0 40100004 f 00000000 0 773456ff
0 40100000 f 00000000 0 11223344
1 40100010 f 00000010 0 00000000
1 40100014 f 00000014 0 00000000
1 40100018 f 00000018 0 00000000
0 40100010 f 00000000 0 00000010
0 40100014 f 00000000 0 00000014
0 40100018 f 00000000 0 00000018
1 40100014 c abcd0000 0 00000000
0 40100014 f 00000000 0 abcd0014
1 401003fe 2 00005500 0 00000000
0 401003fd f 00000000 0 cafe550d
0 40100bfc f 00000000 1 00000000
1 40100000 f 55aa55aa 0 00000000
0 40100000 f 00000000 0 55aa55aa
0 401003fc f 00000000 0 cafe550d

/* sim/ctn_ram_asserts.sv */
/*
 * Assertions bound to the CTN top level
 */
`timescale 1ns/1ps
`default_nettype none

module ctn_ram_asserts (
  input wire               clk_aon,
  input wire               rst_n_i,
  input ctn_pkg::ctn_rsp_t rsp_i,
  input logic              supply_ok_i,
  input logic              ready_i
);

  // Path is held off until power-on is done
  rsp_needs_ready: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
      !ready_i |-> !rsp_i.valid)
    else $error("Response valid while ready is low");

  ready_sticky: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
      ready_i |=> ready_i)
    else $error("Ready fell after it had risen");

  supply_with_ready: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
      ready_i |-> supply_ok_i)
    else $error("Supply-good low while ready is high");

  // A miss never carries data
  miss_no_data: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
      (rsp_i.valid && rsp_i.error) |-> (rsp_i.rdata == '0))
    else $error("Error response with nonzero read data");

endmodule

bind ctn_ram_top ctn_ram_asserts u_asserts (
  .clk_aon     (clk_aon),
  .rst_n_i     (rst_n_i),
  .rsp_i       (rsp_o),
  .supply_ok_i (supply_ok_o),
  .ready_i     (ready_o)
);

`default_nettype wire

/* sim/ctn_ram_tb.sv */
/*
 * Testbench for the CTN memory path: clock, reset, power-on level checks,
 * pattern-driven requests with random gaps and in-order response checks
 */
`timescale 1ns/1ps
`default_nettype none

module ctn_ram_tb;

  localparam int          MaxPat    = 64;
  localparam int          PatFields = 6;          // Words per pattern line
  localparam logic [31:0] LfsrSeed  = 32'd98045;

  logic              clk_aon;
  logic              rst_n;
  ctn_pkg::ctn_req_t req;
  ctn_pkg::ctn_rsp_t rsp;
  logic              supply_ok;
  logic              ready;

  logic [31:0]       pat_mem [MaxPat*PatFields];
  logic [31:0]       lfsr_state;
  ctn_pkg::ctn_rsp_t exp_q [$];                  // Expected responses, oldest first
  int                due_q [$];                  // Cycle each response is due
  int                cyc = 0;
  int                limit = 1000;
  int                num_pat = 0;
  int                rsp_idx = 0;
  int                value_errs = 0;
  int                other_errs = 0;

  ctn_ram_top u_dut (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .rsp_o       (rsp),
    .supply_ok_o (supply_ok),
    .ready_o     (ready)
  );

  initial begin
    clk_aon = 1'b0;
    forever #4 clk_aon = ~clk_aon;
  end

  always @(posedge clk_aon) cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // Random gaps
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  // Zero gap more often than not, so bursts show up
  task automatic pick_gap(output int gap);
    int bits;
    draw_bits(3, bits);
    if (bits[2]) begin
      gap = 0;
    end else begin
      gap = bits[1:0];
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_rsp(input int idx, input ctn_pkg::ctn_rsp_t got,
                           input ctn_pkg::ctn_rsp_t exp_rsp);
    if (got.write !== exp_rsp.write || got.error !== exp_rsp.error ||
        got.rdata !== exp_rsp.rdata) begin
      $display("ERROR @%0t: response %0d got write=%0b error=%0b rdata=%08h", $time, idx,
               got.write, got.error, got.rdata);
      $display("ERROR @%0t: response %0d expected write=%0b error=%0b rdata=%08h", $time,
               idx, exp_rsp.write, exp_rsp.error, exp_rsp.rdata);
      value_errs++;
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp_lvl);
    if (got !== exp_lvl) begin
      $display("ERROR @%0t: %s is %0b, expected %0b", $time, what, got, exp_lvl);
      value_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Response monitor, samples on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_aon) begin
    if (rst_n) begin
      if (rsp.valid) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected response at cycle %0d with no request outstanding", cyc);
          other_errs++;
        end else begin
          if (due_q[0] != cyc) begin
            $display("Response %0d came at cycle %0d instead of %0d", rsp_idx, cyc, due_q[0]);
            other_errs++;
          end
          check_rsp(rsp_idx, rsp, exp_q.pop_front());
          void'(due_q.pop_front());
          rsp_idx++;
        end
      end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
        $display("Response %0d never arrived, it was due at cycle %0d", rsp_idx, due_q[0]);
        other_errs++;
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
        rsp_idx++;
      end
    end
  end

  always @(posedge clk_aon) begin
    if (cyc >= limit) begin
      $display("Timeout at cycle %0d with %0d responses still outstanding", cyc,
               exp_q.size());
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                gap;
    int                base;
    ctn_pkg::ctn_rsp_t exp_rsp;
    rst_n      = 1'b0;
    req        = '0;
    lfsr_state = LfsrSeed;
    for (int i = 0; i < MaxPat * PatFields; i++) begin
      pat_mem[i] = ~32'(i);  // Never 0 or 1, so it marks the end
    end
    $readmemh("sim/ctn_patterns.txt", pat_mem);
    while (num_pat < MaxPat && pat_mem[num_pat*PatFields] <= 32'd1) begin
      num_pat++;
    end
    limit = 100 + 5 * num_pat;
    if (num_pat == 0) begin
      $display("No patterns could be read from sim/ctn_patterns.txt");
      other_errs++;
    end

    // Everything low while in reset
    repeat (9) @(posedge clk_aon);
    @(negedge clk_aon);
    check_level("rsp valid in reset", rsp.valid, 1'b0);
    check_level("supply_ok in reset", supply_ok, 1'b0);
    check_level("ready in reset", ready, 1'b0);
    @(posedge clk_aon);
    #1 rst_n = 1'b1;

    // Power-on pattern, with writes that must be dropped until ready
    for (int k = 1; k <= ctn_pkg::PorSatCount + 2; k++) begin
      @(posedge clk_aon);
      #1;
      req = '0;
      if (k < ctn_pkg::PorSatCount) begin
        req.valid    = 1'b1;
        req.write    = 1'b1;
        req.addr.raw = ctn_pkg::CtnBaseAddr + ctn_pkg::RamOffset;
        req.mask     = 4'hF;
        req.wdata    = 32'hBAD0_0000 | k;
      end
      @(negedge clk_aon);
      check_level("supply_ok", supply_ok, (k >= 4 && k <= 7) || k >= 12);
      check_level("ready", ready, k >= ctn_pkg::PorSatCount);
    end

    for (int p = 0; p < num_pat; p++) begin
      base = p * PatFields;
      pick_gap(gap);
      repeat (gap) begin
        @(posedge clk_aon);
        #1 req = '0;
      end
      @(posedge clk_aon);
      #1;
      req.valid     = 1'b1;
      req.write     = pat_mem[base][0];
      req.addr.raw  = pat_mem[base+1];
      req.mask      = pat_mem[base+2][3:0];
      req.wdata     = pat_mem[base+3];
      exp_rsp.valid = 1'b1;
      exp_rsp.write = pat_mem[base][0];
      exp_rsp.error = pat_mem[base+4][0];
      exp_rsp.rdata = pat_mem[base+5];
      exp_q.push_back(exp_rsp);
      due_q.push_back(cyc + 3);  // Registered on the third edge after this drive
    end
    @(posedge clk_aon);
    #1 req = '0;

    while (exp_q.size() != 0) @(negedge clk_aon);
    repeat (4) @(negedge clk_aon);  // Room for a stray response
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
